//--- hdl/crc24_pkg.sv
package crc24_pkg;

    //////////////////////////////
    // widths
    //////////////////////////////

    // crc register width
    localparam int crc_width  = 24;
    // one data word on the link
    localparam int word_width = 64;
    // words carried by one beat
    localparam int lane_count = 4;

    typedef logic [crc_width-1:0]            crc_t;
    typedef logic [word_width-1:0]           word_t;
    // number of valid words minus one
    typedef logic [$clog2(lane_count)-1:0]   count_t;

    //////////////////////////////
    // polynomial and seed
    //////////////////////////////

    // x^24 term is implied
    localparam crc_t crc_poly = 24'h328B63;
    // start of packet value, also the output after reset
    localparam crc_t crc_init = '1;

    //////////////////////////////
    // beat formats
    //////////////////////////////

    // input beat, lane 0 holds the oldest word
    typedef struct packed {
        logic                     valid;
        logic                     sop;
        logic                     eop;
        count_t                   count_m1;
        word_t [lane_count-1:0]   words;
    } beat_t;

    // same beat after dispatch, slot 0 holds the newest word
    // slots above count_m1 are zero
    typedef struct packed {
        logic                     valid;
        logic                     sop;
        logic                     eop;
        count_t                   count_m1;
        word_t [lane_count-1:0]   words;
    } slot_beat_t;

    // zero seeded crc of every slot word
    typedef struct packed {
        logic                     valid;
        logic                     sop;
        logic                     eop;
        count_t                   count_m1;
        crc_t [lane_count-1:0]    crcs;
    } slot_crc_t;

    // one msb first bit step of the crc shift register
    function automatic crc_t crc_bit_step(crc_t c, logic b);
        logic fb;
        fb = c[crc_width-1] ^ b;
        return {c[crc_width-2:0], 1'b0} ^ (fb ? crc_poly : crc_t'(0));
    endfunction

endpackage

//--- hdl/crc24_zero_advance.sv
`timescale 1ns/1ps

module crc24_zero_advance
    import crc24_pkg::*;
#(
    // zero words to step through, 1 to 4
    parameter int n_words = 1
) (
    input  crc_t c,
    output crc_t crc_out
);

    //////////////////////////////
    // zero word evolution
    //////////////////////////////

    // data bits are all zero so only the feedback term remains
    // synthesis folds the loop into a fixed xor matrix
    always_comb begin
        crc_t state;
        state = c;
        for (int b = 0; b < n_words * word_width; b++) begin
            state = crc_bit_step(state, 1'b0);
        end
        crc_out = state;
    end

endmodule

//--- hdl/crc24_word_lane.sv
`timescale 1ns/1ps

module crc24_word_lane
    import crc24_pkg::*;
(
    input  logic  clk,
    input  logic  arst,
    input  logic  ena,
    input  word_t word,
    output crc_t  crc
);

    //////////////////////////////
    // single word crc
    //////////////////////////////

    // zero seed, so the result is a pure function of the word
    // and can later be moved to its place in the packet by linearity
    crc_t crc_next;

    always_comb begin
        crc_t state;
        state = '0;
        // msb first, bit 63 enters the register first
        for (int b = word_width - 1; b >= 0; b--) begin
            state = crc_bit_step(state, word[b]);
        end
        crc_next = state;
    end

    //////////////////////////////
    // lane register
    //////////////////////////////

    // runs every enabled cycle
    // idle slots carry zero words and give zero terms
    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            crc <= '0;
        end else if (ena) begin
            crc <= crc_next;
        end
    end

endmodule

//--- hdl/crc24_beat_dispatch.sv
`timescale 1ns/1ps

module crc24_beat_dispatch
    import crc24_pkg::*;
(
    input  logic       clk,
    input  logic       arst,
    input  logic       ena,
    input  beat_t      in_beat,
    output slot_beat_t slot_beat
);

    //////////////////////////////
    // slot reorder
    //////////////////////////////

    // slot i takes lane count_m1 - i
    // slots past the last word get zero so their lane crc is zero
    word_t [lane_count-1:0] slot_words;

    always_comb begin
        int idx;
        for (int i = 0; i < lane_count; i++) begin
            idx = int'(in_beat.count_m1) - i;
            if (idx >= 0) begin
                slot_words[i] = in_beat.words[idx];
            end else begin
                slot_words[i] = '0;
            end
        end
    end

    //////////////////////////////
    // beat register
    //////////////////////////////

    logic                   valid_q;
    logic                   sop_q;
    logic                   eop_q;
    count_t                 count_m1_q;
    word_t [lane_count-1:0] words_q;

    // control fields
    // idle beat only drops valid, the rest holds to save toggling
    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            valid_q    <= 1'b0;
            sop_q      <= 1'b0;
            eop_q      <= 1'b0;
            count_m1_q <= '0;
        end else if (ena) begin
            valid_q <= in_beat.valid;
            if (in_beat.valid) begin
                sop_q      <= in_beat.sop;
                eop_q      <= in_beat.eop;
                count_m1_q <= in_beat.count_m1;
            end
        end
    end

    // payload words
    always_ff @(posedge clk) begin
        if (ena && in_beat.valid) begin
            words_q <= slot_words;
        end
    end

    assign slot_beat = '{
        valid:    valid_q,
        sop:      sop_q,
        eop:      eop_q,
        count_m1: count_m1_q,
        words:    words_q
    };

endmodule

//--- hdl/crc24_multi_combine.sv
`timescale 1ns/1ps

module crc24_multi_combine
    import crc24_pkg::*;
(
    input  logic      clk,
    input  logic      arst,
    input  logic      ena,
    input  slot_crc_t slot_crc,
    output crc_t      crc_out,
    output logic      crc_valid,
    output logic      crc_last
);

    //////////////////////////////
    // slot term evolution
    //////////////////////////////

    // slot i is i words older than slot 0
    // so its crc must travel through i zero words to line up
    crc_t [lane_count-1:0] slot_adv;

    // newest word needs no shift
    assign slot_adv[0] = slot_crc.crcs[0];

    for (genvar i = 1; i < lane_count; i++) begin : g_slot_adv
        crc24_zero_advance #(
            .n_words(i)
        ) i_adv (
            .c      (slot_crc.crcs[i]),
            .crc_out(slot_adv[i])
        );
    end

    //////////////////////////////
    // stage one
    //////////////////////////////

    logic                  s1_valid;
    logic                  s1_sop;
    logic                  s1_eop;
    count_t                s1_count_m1;
    crc_t [lane_count-1:0] term_q;

    // control of the beat in flight
    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            s1_valid    <= 1'b0;
            s1_sop      <= 1'b0;
            s1_eop      <= 1'b0;
            s1_count_m1 <= '0;
        end else if (ena) begin
            s1_valid    <= slot_crc.valid;
            s1_sop      <= slot_crc.sop;
            s1_eop      <= slot_crc.eop;
            s1_count_m1 <= slot_crc.count_m1;
        end
    end

    // masked data terms
    // slots past count_m1 drop out of the sum
    always_ff @(posedge clk) begin
        if (ena) begin
            for (int i = 0; i < lane_count; i++) begin
                if (i <= int'(slot_crc.count_m1)) begin
                    term_q[i] <= slot_adv[i];
                end else begin
                    term_q[i] <= '0;
                end
            end
        end
    end

    //////////////////////////////
    // prior state
    //////////////////////////////

    // restart from the seed on sop, otherwise carry the running crc
    // this select sits one cycle behind the data terms
    crc_t                  prior;
    crc_t [lane_count-1:0] prior_adv;

    assign prior = s1_sop ? crc_init : crc_out;

    // prior_adv[k] is the prior state moved past k+1 new words
    for (genvar k = 0; k < lane_count; k++) begin : g_prior_adv
        crc24_zero_advance #(
            .n_words(k + 1)
        ) i_adv (
            .c      (prior),
            .crc_out(prior_adv[k])
        );
    end

    //////////////////////////////
    // stage two
    //////////////////////////////

    crc_t crc_next;

    // running crc is the xor of all shifted contributions
    always_comb begin
        crc_t acc;
        acc = prior_adv[s1_count_m1];
        for (int i = 0; i < lane_count; i++) begin
            acc = acc ^ term_q[i];
        end
        crc_next = acc;
    end

    // feedback closes here in one cycle, beats can run back to back
    // crc_out keeps its value between results
    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            crc_out   <= crc_init;
            crc_valid <= 1'b0;
            crc_last  <= 1'b0;
        end else if (ena) begin
            crc_valid <= s1_valid;
            crc_last  <= s1_valid & s1_eop;
            if (s1_valid) begin
                crc_out <= crc_next;
            end
        end
    end

endmodule

//--- hdl/crc24_packet_engine.sv
`timescale 1ns/1ps

module crc24_packet_engine
    import crc24_pkg::*;
(
    input  logic  clk,
    input  logic  arst,
    input  logic  ena,
    input  beat_t in_beat,
    output crc_t  crc_out,
    output logic  crc_valid,
    output logic  crc_last
);

    //////////////////////////////
    // dispatch
    //////////////////////////////

    slot_beat_t slot_beat;

    crc24_beat_dispatch i_dispatch (
        .clk      (clk),
        .arst     (arst),
        .ena      (ena),
        .in_beat  (in_beat),
        .slot_beat(slot_beat)
    );

    //////////////////////////////
    // word lanes
    //////////////////////////////

    crc_t [lane_count-1:0] lane_crc;
    logic                  ctrl_valid;
    logic                  ctrl_sop;
    logic                  ctrl_eop;
    count_t                ctrl_count_m1;
    slot_crc_t             slot_crc;

    for (genvar i = 0; i < lane_count; i++) begin : g_lane
        crc24_word_lane i_lane (
            .clk (clk),
            .arst(arst),
            .ena (ena),
            .word(slot_beat.words[i]),
            .crc (lane_crc[i])
        );

        // control rides alongside lane 0 to match lane latency
        if (i == 0) begin : g_ctrl
            always_ff @(posedge clk or posedge arst) begin
                if (arst) begin
                    ctrl_valid    <= 1'b0;
                    ctrl_sop      <= 1'b0;
                    ctrl_eop      <= 1'b0;
                    ctrl_count_m1 <= '0;
                end else if (ena) begin
                    ctrl_valid    <= slot_beat.valid;
                    ctrl_sop      <= slot_beat.sop;
                    ctrl_eop      <= slot_beat.eop;
                    ctrl_count_m1 <= slot_beat.count_m1;
                end
            end
        end
    end

    assign slot_crc = '{
        valid:    ctrl_valid,
        sop:      ctrl_sop,
        eop:      ctrl_eop,
        count_m1: ctrl_count_m1,
        crcs:     lane_crc
    };

    //////////////////////////////
    // combiner
    //////////////////////////////

    crc24_multi_combine i_combine (
        .clk      (clk),
        .arst     (arst),
        .ena      (ena),
        .slot_crc (slot_crc),
        .crc_out  (crc_out),
        .crc_valid(crc_valid),
        .crc_last (crc_last)
    );

endmodule

//--- verification/crc24_tb.sv
`timescale 1ns/1ps

module crc24_tb
    import crc24_pkg::*;
();

    localparam int clk_period_ns = 100;
    // packets in the run
    // the first four are single word
    localparam int n_packets     = 60;
    localparam int drain_cycles  = 8;

    // expected result of one accepted beat
    typedef struct packed {
        crc_t crc;
        logic last;
    } expect_t;

    logic  clk;
    logic  arst;
    logic  ena;
    beat_t in_beat;
    crc_t  crc_out;
    logic  crc_valid;
    logic  crc_last;

    beat_t       plan_beats[$];
    expect_t     plan_exp[$];
    expect_t     result_q[$];
    logic [31:0] rng_state = 32'd52;
    logic        plan_done = 1'b0;
    logic        reset_done = 1'b0;
    int          n_accepted = 0;
    int          n_results = 0;
    crc_t        last_crc = crc_init;

    crc24_packet_engine i_dut (
        .clk      (clk),
        .arst     (arst),
        .ena      (ena),
        .in_beat  (in_beat),
        .crc_out  (crc_out),
        .crc_valid(crc_valid),
        .crc_last (crc_last)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period_ns / 2) clk = ~clk;
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // uniform-ish draw in 0 .. n-1
    function automatic int rand_below(input int n);
        rng_state = xorshift32(rng_state);
        return int'(rng_state % n);
    endfunction

    function automatic word_t rand_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = xorshift32(rng_state);
        lo = xorshift32(hi);
        rng_state = lo;
        return {hi, lo};
    endfunction

    // bit serial crc from the seed with the msb of each word first
    function automatic crc_t crc_ref(input word_t words[$]);
        crc_t c;
        logic fb;
        c = crc_init;
        foreach (words[w]) begin
            for (int b = word_width - 1; b >= 0; b--) begin
                fb = c[crc_width-1] ^ words[w][b];
                c  = {c[crc_width-2:0], 1'b0};
                if (fb) begin
                    c = c ^ crc_poly;
                end
            end
        end
        return c;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_crc(input crc_t got, input crc_t exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t: crc_out is %h, expected %h", $time, got, exp));
        end
    endtask

    task automatic check_last(input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t: crc_last is %b, expected %b", $time, got, exp));
        end
    endtask

    //////////////////////////////
    // stimulus schedule
    //////////////////////////////

    // packets are cut into beats of 1 to 4 words
    // lanes past count_m1 carry junk that must not reach the crc
    // some packets drop eop so the next sop restarts mid packet
    task automatic build_plan();
        word_t   pkt_words[$];
        beat_t   b;
        expect_t e;
        int      len;
        int      left;
        int      cnt;
        logic    drop_eop;
        for (int p = 0; p < n_packets; p++) begin
            len      = (p < 4) ? 1 : 1 + rand_below(20);
            drop_eop = (p >= 4) && (rand_below(8) == 0);
            pkt_words.delete();
            left = len;
            while (left > 0) begin
                cnt = 1 + rand_below(4);
                if (cnt > left) begin
                    cnt = left;
                end
                b          = '0;
                b.valid    = 1'b1;
                b.sop      = (left == len);
                b.count_m1 = count_t'(cnt - 1);
                for (int l = 0; l < lane_count; l++) begin
                    b.words[l] = rand_word();
                    if (l < cnt) begin
                        pkt_words.push_back(b.words[l]);
                    end
                end
                left   = left - cnt;
                b.eop  = (left == 0) && !drop_eop;
                e.crc  = crc_ref(pkt_words);
                e.last = b.eop;
                plan_beats.push_back(b);
                plan_exp.push_back(e);
            end
        end
    endtask

    //////////////////////////////
    // drive
    //////////////////////////////

    initial begin
        beat_t b;
        int    stall;
        arst    = 1'b1;
        ena     = 1'b0;
        in_beat = '0;
        build_plan();
        plan_done = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst = 1'b0;
        // outputs idle right after reset
        check_crc(crc_out, crc_init);
        check_last(crc_last, 1'b0);
        if (crc_valid !== 1'b0) begin
            abort_run("crc_valid is high after reset before any beat was sent");
        end
        reset_done = 1'b1;
        foreach (plan_beats[n]) begin
            b = plan_beats[n];
            // idle beat with junk fields and valid low
            if (rand_below(8) == 0) begin
                ena           = 1'b1;
                in_beat       = b;
                in_beat.valid = 1'b0;
                @(negedge clk);
            end
            // frozen cycles where the beat is presented but must not be taken
            if (rand_below(6) == 0) begin
                stall = 1 + rand_below(2);
                repeat (stall) begin
                    ena     = 1'b0;
                    in_beat = b;
                    @(negedge clk);
                end
            end
            ena     = 1'b1;
            in_beat = b;
            result_q.push_back(plan_exp[n]);
            n_accepted++;
            @(negedge clk);
        end
        ena     = 1'b1;
        in_beat = '0;
        repeat (drain_cycles) @(negedge clk);
        if (result_q.size() != 0 || n_results != n_accepted) begin
            abort_run($sformatf("%0d beats were accepted but only %0d results came out",
                                n_accepted, n_results));
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

    //////////////////////////////
    // compare
    //////////////////////////////

    // ena is sampled at the rising edge and the outputs half a cycle later
    initial begin
        expect_t e;
        logic    enabled;
        wait (reset_done);
        forever begin
            @(posedge clk);
            enabled = ena;
            @(negedge clk);
            if (enabled && crc_valid) begin
                if (result_q.size() == 0) begin
                    abort_run("the DUT produced a result with no beat waiting for one");
                end
                e = result_q.pop_front();
                check_crc(crc_out, e.crc);
                check_last(crc_last, e.last);
                last_crc = e.crc;
                n_results++;
            end else begin
                // with no fresh result crc_out must hold
                check_crc(crc_out, last_crc);
                if (enabled) begin
                    check_last(crc_last, 1'b0);
                end
            end
        end
    end

    // each planned beat takes at most four cycles with stalls
    initial begin
        wait (plan_done);
        #((plan_beats.size() * 4 + 50) * clk_period_ns);
        abort_run("timeout, the run did not finish in the expected number of cycles");
    end

endmodule

//--- project.f
hdl/crc24_pkg.sv
hdl/crc24_zero_advance.sv
hdl/crc24_word_lane.sv
hdl/crc24_beat_dispatch.sv
hdl/crc24_multi_combine.sv
hdl/crc24_packet_engine.sv
verification/crc24_tb.sv
